/* build.f */
src/stream_source_pkg.sv
src/source_addr_gen.sv
src/source_ctrl_fsm.sv
src/tcdm_port_buffer.sv
src/stream_merge.sv
src/stream_source.sv
tests/tb_mem_model.sv
tests/tb_stream_source.sv

/* run_sim.sh */
#!/usr/bin/env bash
# compile and run the stream source testbench with verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps -j 0 \
  --top-module tb_stream_source -f build.f -o sim_stream_source
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

./obj_dir/sim_stream_source > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Simulation finished: FAIL" "$LOG"; then
  exit 1
fi
if ! grep -q "Simulation finished: PASS" "$LOG"; then
  echo "no result line in $LOG"
  exit 1
fi
exit 0

/* src/source_addr_gen.sv */
// ==========================================================
// source address generator
// walks a 2d word aligned pattern one wide beat per advance
// and flags the last beat of the job
// ==========================================================

`timescale 1ns/1ps

module source_addr_gen (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     clear_i,
  input  logic                     start_i,       // accepted job start
  input  logic                     advance_i,     // beat granted, step on
  input  stream_source_pkg::addr_t base_addr_i,
  input  stream_source_pkg::cnt_t  line_length_i,
  input  stream_source_pkg::addr_t line_stride_i,
  input  stream_source_pkg::cnt_t  trans_size_i,
  output stream_source_pkg::addr_t addr_o,
  output logic                     last_o
);

  stream_source_pkg::addr_t line_start_q;  // first beat of current line
  stream_source_pkg::addr_t addr_q;        // current beat address
  stream_source_pkg::cnt_t  pos_q;         // beat position inside the line
  stream_source_pkg::cnt_t  beat_cnt_q;    // beats already advanced
  stream_source_pkg::addr_t next_line;
  logic                     line_end;

  assign next_line = line_start_q + line_stride_i;
  assign line_end  = (pos_q == line_length_i - stream_source_pkg::cnt_t'(1));

  // walker state
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      line_start_q <= '0;
      addr_q       <= '0;
      pos_q        <= '0;
      beat_cnt_q   <= '0;
    end else if (clear_i) begin
      line_start_q <= '0;
      addr_q       <= '0;
      pos_q        <= '0;
      beat_cnt_q   <= '0;
    end else if (start_i) begin
      // job begins at the base address
      line_start_q <= base_addr_i;
      addr_q       <= base_addr_i;
      pos_q        <= '0;
      beat_cnt_q   <= '0;
    end else if (advance_i) begin
      beat_cnt_q <= beat_cnt_q + stream_source_pkg::cnt_t'(1);
      if (line_end) begin
        // wrap to the start of the next line
        line_start_q <= next_line;
        addr_q       <= next_line;
        pos_q        <= '0;
      end else begin
        addr_q <= addr_q + stream_source_pkg::addr_t'(stream_source_pkg::BEAT_BYTES);
        pos_q  <= pos_q + stream_source_pkg::cnt_t'(1);
      end
    end
  end

  assign addr_o = addr_q;

  // final beat of the job, straight from the counter
  assign last_o = (beat_cnt_q == trans_size_i - stream_source_pkg::cnt_t'(1));

endmodule

/* src/source_ctrl_fsm.sv */
// ==========================================================
// source controller
// idle/working job sequencer, raises the grouped memory
// request and pulses done after the last grant
// ==========================================================

`timescale 1ns/1ps

module source_ctrl_fsm (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic clear_i,
  input  logic start_i,       // job request from the controller
  input  logic ready_i,       // stream sink ready
  input  logic gnt_i,         // group grant from memory
  input  logic last_i,        // generator sits on the last beat
  output logic req_o,         // group load request
  output logic advance_o,     // step the address generator
  output logic job_start_o,   // accepted start, loads the generator
  output logic ready_start_o,
  output logic busy_o,
  output logic done_o
);

  stream_source_pkg::source_state_e state_q, state_d;
  logic                             done_q;
  logic                             last_gnt;

  // request only while the sink can take the returning beat
  assign req_o       = (state_q == stream_source_pkg::SRC_WORKING) & ready_i;
  assign advance_o   = req_o & gnt_i;
  assign last_gnt    = advance_o & last_i;
  assign job_start_o = (state_q == stream_source_pkg::SRC_IDLE) & start_i;

  // status flags
  assign ready_start_o = (state_q == stream_source_pkg::SRC_IDLE);
  assign busy_o        = (state_q == stream_source_pkg::SRC_WORKING);
  assign done_o        = done_q;

  // next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      stream_source_pkg::SRC_IDLE: begin
        if (start_i) begin
          state_d = stream_source_pkg::SRC_WORKING;
        end
      end
      stream_source_pkg::SRC_WORKING: begin
        if (last_gnt) begin
          state_d = stream_source_pkg::SRC_IDLE;  // last load is out
        end
      end
      default: begin
        state_d = stream_source_pkg::SRC_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= stream_source_pkg::SRC_IDLE;
      done_q  <= 1'b0;
    end else if (clear_i) begin
      state_q <= stream_source_pkg::SRC_IDLE;
      done_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      done_q  <= last_gnt;  // lines up with the last beat going valid
    end
  end

endmodule

/* src/stream_merge.sv */
// ==========================================================
// stream merge
// joins the per-port words into one wide beat and retires
// all ports together on a sink handshake
// ==========================================================

`timescale 1ns/1ps

module stream_merge (
  input  logic [stream_source_pkg::NB_PORTS-1:0] valid_i,
  input  stream_source_pkg::word_t               data_i [stream_source_pkg::NB_PORTS],
  output logic [stream_source_pkg::NB_PORTS-1:0] ready_o,
  output logic                                   valid_o,
  output stream_source_pkg::data_t               data_o,
  input  logic                                   ready_i
);

  logic all_valid;
  logic beat_hs;  // wide beat accepted

  // beat exists only once every port has its word
  assign all_valid = &valid_i;
  assign valid_o   = all_valid;
  assign beat_hs   = all_valid & ready_i;

  // pack in port order
  always_comb begin
    data_o = '0;
    for (int i = 0; i < stream_source_pkg::NB_PORTS; i++) begin
      data_o[i*stream_source_pkg::WORD_W +: stream_source_pkg::WORD_W] = data_i[i];
    end
  end

  // same ready to every port so none runs ahead
  always_comb begin
    for (int i = 0; i < stream_source_pkg::NB_PORTS; i++) begin
      ready_o[i] = beat_hs;
    end
  end

endmodule

/* src/stream_source.sv */
// ==========================================================
// stream source
// memory to stream source streamer, loads a 2d pattern on
// parallel tcdm ports and emits one wide valid/ready stream
// ==========================================================

`timescale 1ns/1ps

module stream_source (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  input  logic                                   clear_i,
  // control
  input  logic                                   start_i,
  input  stream_source_pkg::addr_t               base_addr_i,
  input  stream_source_pkg::cnt_t                trans_size_i,
  input  stream_source_pkg::cnt_t                line_length_i,
  input  stream_source_pkg::addr_t               line_stride_i,
  output logic                                   ready_start_o,
  output logic                                   busy_o,
  output logic                                   done_o,
  // memory ports
  output logic [stream_source_pkg::NB_PORTS-1:0] mem_req_o,
  output stream_source_pkg::addr_t               mem_addr_o [stream_source_pkg::NB_PORTS],
  input  logic                                   mem_gnt_i,   // one grant per group
  input  logic [stream_source_pkg::NB_PORTS-1:0] mem_rvalid_i,
  input  stream_source_pkg::word_t               mem_rdata_i [stream_source_pkg::NB_PORTS],
  // output stream
  output stream_source_pkg::data_t               data_o,
  output logic                                   valid_o,
  input  logic                                   ready_i
);

  logic                                   job_start;
  logic                                   advance;
  logic                                   last_beat;
  logic                                   group_req;
  stream_source_pkg::addr_t               beat_addr;
  logic [stream_source_pkg::NB_PORTS-1:0] port_valid;
  logic [stream_source_pkg::NB_PORTS-1:0] port_ready;
  stream_source_pkg::word_t               port_data [stream_source_pkg::NB_PORTS];

  source_ctrl_fsm i_ctrl_fsm (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .clear_i       ( clear_i       ),
    .start_i       ( start_i       ),
    .ready_i       ( ready_i       ),
    .gnt_i         ( mem_gnt_i     ),
    .last_i        ( last_beat     ),
    .req_o         ( group_req     ),
    .advance_o     ( advance       ),
    .job_start_o   ( job_start     ),
    .ready_start_o ( ready_start_o ),
    .busy_o        ( busy_o        ),
    .done_o        ( done_o        )
  );

  source_addr_gen i_addr_gen (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .clear_i       ( clear_i       ),
    .start_i       ( job_start     ),
    .advance_i     ( advance       ),
    .base_addr_i   ( base_addr_i   ),
    .line_length_i ( line_length_i ),
    .line_stride_i ( line_stride_i ),
    .trans_size_i  ( trans_size_i  ),
    .addr_o        ( beat_addr     ),
    .last_o        ( last_beat     )
  );

  // one load port per word of the beat
  for (genvar i = 0; i < stream_source_pkg::NB_PORTS; i++) begin : gen_port
    assign mem_req_o[i]  = group_req;  // whole group asks together
    assign mem_addr_o[i] = beat_addr
                         + stream_source_pkg::addr_t'(i * stream_source_pkg::WORD_BYTES);

    tcdm_port_buffer i_port_buffer (
      .clk_i    ( clk_i           ),
      .rst_ni   ( rst_ni          ),
      .clear_i  ( clear_i         ),
      .rvalid_i ( mem_rvalid_i[i] ),
      .rdata_i  ( mem_rdata_i[i]  ),
      .valid_o  ( port_valid[i]   ),
      .data_o   ( port_data[i]    ),
      .ready_i  ( port_ready[i]   )
    );
  end

  stream_merge i_merge (
    .valid_i ( port_valid ),
    .data_i  ( port_data  ),
    .ready_o ( port_ready ),
    .valid_o ( valid_o    ),
    .data_o  ( data_o     ),
    .ready_i ( ready_i    )
  );

endmodule

/* src/stream_source_pkg.sv */
// ==========================================================
// stream source package
// widths, port count and shared types of the memory to
// stream source streamer
// ==========================================================

package stream_source_pkg;

  // memory side
  localparam int unsigned WORD_W     = 32;  // one tcdm word
  localparam int unsigned NB_PORTS   = 2;   // parallel load ports
  localparam int unsigned ADDR_W     = 32;  // byte address
  localparam int unsigned WORD_BYTES = WORD_W / 8;

  // stream side
  localparam int unsigned DATA_W     = WORD_W * NB_PORTS;
  localparam int unsigned BEAT_BYTES = WORD_BYTES * NB_PORTS; // addr step per beat

  // job counters
  localparam int unsigned CNT_W      = 16;

  // byte address
  typedef logic [ADDR_W-1:0] addr_t;

  // single memory word
  typedef logic [WORD_W-1:0] word_t;

  // wide output beat, port 0 sits in the low word
  typedef logic [DATA_W-1:0] data_t;

  // transfer size, line length and position counters
  typedef logic [CNT_W-1:0]  cnt_t;

  // job controller states
  typedef enum logic {
    SRC_IDLE    = 1'b0,  // waiting for a start
    SRC_WORKING = 1'b1   // issuing loads
  } source_state_e;

endpackage

/* src/tcdm_port_buffer.sv */
// ==========================================================
// tcdm port buffer
// passes a returning load word straight through and keeps
// it for later when the stream is stalled
// ==========================================================

`timescale 1ns/1ps

module tcdm_port_buffer (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     clear_i,
  input  logic                     rvalid_i,  // response from memory
  input  stream_source_pkg::word_t rdata_i,
  output logic                     valid_o,   // towards the merge
  output stream_source_pkg::word_t data_o,
  input  logic                     ready_i
);

  logic                     valid_q;  // a word is parked
  stream_source_pkg::word_t data_q;

  // fresh response wins, otherwise the parked one
  assign valid_o = rvalid_i | valid_q;
  assign data_o  = rvalid_i ? rdata_i : data_q;

  // occupancy
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (clear_i) begin
      valid_q <= 1'b0;
    end else begin
      if (rvalid_i & ready_i) begin
        valid_q <= 1'b0;       // bypassed in the same cycle
      end else if (rvalid_i) begin
        valid_q <= 1'b1;       // stalled, keep it
      end else if (valid_q & ready_i) begin
        valid_q <= 1'b0;       // parked word retired
      end
    end
  end

  // word storage
  always_ff @(posedge clk_i) begin
    if (rvalid_i) begin
      data_q <= rdata_i;
    end
  end

endmodule

/* tests/tb_mem_model.sv */
// ==========================================================
// tcdm memory model
// grants the port group with random stalls and answers each
// load one cycle later with data taken from its address
// ==========================================================

`timescale 1ns/1ps

module tb_mem_model (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  input  logic                                   stall_en_i,  // random grant gaps
  input  logic [stream_source_pkg::NB_PORTS-1:0] req_i,
  input  stream_source_pkg::addr_t               addr_i [stream_source_pkg::NB_PORTS],
  output logic                                   gnt_o,
  output logic [stream_source_pkg::NB_PORTS-1:0] rvalid_o,
  output stream_source_pkg::word_t               rdata_o [stream_source_pkg::NB_PORTS]
);

  localparam stream_source_pkg::word_t DATA_KEY = 32'h5a5a_0000;  // word = addr ^ key

  logic gnt_en_q;  // grant allowed this cycle

  // whole group granted as one through port 0
  assign gnt_o = req_i[0] & gnt_en_q;

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      gnt_en_q <= 1'b0;
      rvalid_o <= '0;
    end else begin
      gnt_en_q <= stall_en_i ? (($urandom % 3) != 0) : 1'b1;  // about one stall in three
      for (int i = 0; i < stream_source_pkg::NB_PORTS; i++) begin
        rvalid_o[i] <= req_i[i] & gnt_o;  // one cycle read latency
      end
    end
  end

  // read data depends on the full word address
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < stream_source_pkg::NB_PORTS; i++) begin
        rdata_o[i] <= '0;
      end
    end else begin
      for (int i = 0; i < stream_source_pkg::NB_PORTS; i++) begin
        if (req_i[i] & gnt_o) begin
          rdata_o[i] <= stream_source_pkg::word_t'(addr_i[i]) ^ DATA_KEY;
        end
      end
    end
  end

endmodule

/* tests/tb_stream_source.sv */
// ==========================================================
// stream source testbench
// runs linear, 2d, stalled and cleared jobs against the
// memory model and checks every beat and control flag
// ==========================================================

`timescale 1ns/1ps

module tb_stream_source;

  localparam int unsigned TOTAL_BEATS    = 137;  // sum of all job sizes below
  localparam int unsigned TIMEOUT_CYCLES = 10 * TOTAL_BEATS + 200;
  localparam logic [1:0]  RDY_HIGH       = 2'd0;
  localparam logic [1:0]  RDY_RANDOM     = 2'd1;
  localparam logic [1:0]  RDY_LOW        = 2'd2;
  localparam stream_source_pkg::word_t DATA_KEY = 32'h5a5a_0000;

  logic                                   clk_i = 1'b0;
  logic                                   rst_ni;
  logic                                   clear_i;
  logic                                   start_i;
  stream_source_pkg::addr_t               base_addr_i;
  stream_source_pkg::cnt_t                trans_size_i;
  stream_source_pkg::cnt_t                line_length_i;
  stream_source_pkg::addr_t               line_stride_i;
  logic                                   ready_start_o;
  logic                                   busy_o;
  logic                                   done_o;
  logic [stream_source_pkg::NB_PORTS-1:0] mem_req_o;
  stream_source_pkg::addr_t               mem_addr_o [stream_source_pkg::NB_PORTS];
  logic                                   mem_gnt_i;
  logic [stream_source_pkg::NB_PORTS-1:0] mem_rvalid_i;
  stream_source_pkg::word_t               mem_rdata_i [stream_source_pkg::NB_PORTS];
  stream_source_pkg::data_t               data_o;
  logic                                   valid_o;
  logic                                   ready_i;

  logic        stall_en;     // random grant gaps in the memory model
  logic [1:0]  ready_mode;   // how the sink drives ready_i
  logic        job_active;   // start accepted and no done seen yet
  int unsigned beat_idx;     // beats accepted in the current job
  int unsigned done_cnt;     // done pulses since the last accepted start
  int unsigned err_cnt    = 0;
  int unsigned check_cnt  = 0;
  int unsigned test_cnt   = 0;
  int unsigned beat_total = 0;
  int unsigned cycle_cnt  = 0;

  always #20 clk_i = ~clk_i;  // 40 ns period

  stream_source UUT (.*);

  tb_mem_model i_mem (
    .clk_i      ( clk_i        ),
    .rst_ni     ( rst_ni       ),
    .stall_en_i ( stall_en     ),
    .req_i      ( mem_req_o    ),
    .addr_i     ( mem_addr_o   ),
    .gnt_o      ( mem_gnt_i    ),
    .rvalid_o   ( mem_rvalid_i ),
    .rdata_o    ( mem_rdata_i  )
  );

  // expected beat k from the 2d address rule
  function automatic stream_source_pkg::data_t ref_beat(input stream_source_pkg::addr_t base,
                                                        input stream_source_pkg::cnt_t  len,
                                                        input stream_source_pkg::addr_t stride,
                                                        input int unsigned              k);
    int unsigned              line_idx;
    int unsigned              pos;
    stream_source_pkg::addr_t beat_addr;
    stream_source_pkg::data_t beat;
    line_idx  = k / 32'(len);
    pos       = k % 32'(len);
    beat_addr = base + stride * line_idx + pos * stream_source_pkg::BEAT_BYTES;
    for (int i = 0; i < stream_source_pkg::NB_PORTS; i++) begin
      beat[i*stream_source_pkg::WORD_W +: stream_source_pkg::WORD_W] =
        (beat_addr + i * stream_source_pkg::WORD_BYTES) ^ DATA_KEY;  // port 0 low
    end
    return beat;
  endfunction

  task automatic check_data(input string name, input stream_source_pkg::data_t exp_val,
                            input stream_source_pkg::data_t act_val);
    check_cnt++;
    if (act_val !== exp_val) begin
      err_cnt++;
      $display("mismatch at %0t: %s expected %h got %h", $time, name, exp_val, act_val);
    end
  endtask

  task automatic check_bit(input string name, input logic exp_val, input logic act_val);
    check_cnt++;
    if (act_val !== exp_val) begin
      err_cnt++;
      $display("mismatch at %0t: %s expected %b got %b", $time, name, exp_val, act_val);
    end
  endtask

  task automatic report_error(input string msg);
    err_cnt++;
    $display("error at %0t: %s", $time, msg);
  endtask

  task automatic report_test(input string name, input int unsigned errs_at_start);
    test_cnt++;
    if (err_cnt == errs_at_start) $display("test %0d %s: passed", test_cnt, name);
    else $display("test %0d %s: failed with %0d errors", test_cnt, name, err_cnt - errs_at_start);
  endtask

  // runs one full job until done is seen and every beat is taken
  task automatic run_job(input string name, input stream_source_pkg::addr_t base,
                         input stream_source_pkg::cnt_t size, input stream_source_pkg::cnt_t len,
                         input stream_source_pkg::addr_t stride, input logic rnd);
    int unsigned errs_at_start;
    errs_at_start = err_cnt;
    @(posedge clk_i);
    base_addr_i   <= base;
    trans_size_i  <= size;
    line_length_i <= len;
    line_stride_i <= stride;
    start_i       <= 1'b1;
    stall_en      <= rnd;
    ready_mode    <= rnd ? RDY_RANDOM : RDY_HIGH;
    @(posedge clk_i);  // handshake taken here
    start_i <= 1'b0;
    while (job_active || beat_idx < 32'(size)) @(posedge clk_i);
    repeat (8) @(posedge clk_i);  // room for stray beats or done pulses
    if (done_cnt != 1) report_error($sformatf("done_o pulsed %0d times in one job", done_cnt));
    report_test(name, errs_at_start);
  endtask

  // aborts a running job with clear_i while a beat sits in the port buffers
  task automatic clear_mid_job();
    int unsigned errs_at_start;
    errs_at_start = err_cnt;
    @(posedge clk_i);
    base_addr_i   <= 32'h0003_0000;
    trans_size_i  <= 16'd40;
    line_length_i <= 16'd8;
    line_stride_i <= 32'h0000_0080;
    start_i       <= 1'b1;
    stall_en      <= 1'b0;
    ready_mode    <= RDY_HIGH;
    @(posedge clk_i);
    start_i <= 1'b0;
    while (beat_idx < 5) @(posedge clk_i);
    ready_mode <= RDY_LOW;
    repeat (2) @(posedge clk_i);  // last granted load lands in the port buffers
    clear_i <= 1'b1;
    @(posedge clk_i);
    clear_i <= 1'b0;
    @(negedge clk_i);
    check_bit("ready_start_o", 1'b1, ready_start_o);
    check_bit("valid_o", 1'b0, valid_o);
    report_test("clear in mid job", errs_at_start);
  endtask

  // sink ready driver
  initial begin
    ready_i = 1'b0;
    forever begin
      @(posedge clk_i);
      case (ready_mode)
        RDY_RANDOM: ready_i <= ($urandom % 4) != 0;
        RDY_LOW:    ready_i <= 1'b0;
        default:    ready_i <= 1'b1;
      endcase
    end
  end

  // monitor samples mid cycle where everything has settled
  initial begin
    job_active = 1'b0;
    beat_idx   = 0;
    done_cnt   = 0;
    forever begin
      @(negedge clk_i);
      if (rst_ni) begin
        if (done_o) begin
          done_cnt++;
        end
        if (job_active && done_o) begin
          check_bit("valid_o", 1'b1, valid_o);  // last beat goes valid with done
          check_bit("ready_start_o", 1'b1, ready_start_o);
          check_bit("busy_o", 1'b0, busy_o);
          if (beat_idx + 1 != 32'(trans_size_i)) report_error("done_o came before the last beat");
          job_active = 1'b0;
        end else if (job_active) begin
          check_bit("ready_start_o", 1'b0, ready_start_o);
          check_bit("busy_o", 1'b1, busy_o);
        end else begin
          if (done_o) report_error("done_o raised outside a job");
          check_bit("ready_start_o", 1'b1, ready_start_o);
          check_bit("busy_o", 1'b0, busy_o);
        end
        if (valid_o && ready_i) begin
          if (beat_idx >= 32'(trans_size_i)) report_error("beat accepted after the end of the job");
          else check_data("data_o", ref_beat(base_addr_i, line_length_i, line_stride_i, beat_idx),
                          data_o);
          beat_idx++;
          beat_total++;
        end
        if (clear_i) begin
          job_active = 1'b0;
        end else if (start_i && ready_start_o) begin
          job_active = 1'b1;  // start accepted at the coming edge
          beat_idx   = 0;
          done_cnt   = 0;
        end
      end
    end
  end

  // run limit
  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("error: run timed out after %0d cycles", cycle_cnt);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  initial begin
    int unsigned errs_at_start;
    void'($urandom(32'h81c6_229f));
    rst_ni        = 1'b0;
    clear_i       = 1'b0;
    start_i       = 1'b0;
    base_addr_i   = '0;
    trans_size_i  = '0;
    line_length_i = '0;
    line_stride_i = '0;
    stall_en      = 1'b0;
    ready_mode    = RDY_HIGH;
    repeat (8) @(posedge clk_i);
    rst_ni <= 1'b1;

    // idle flags straight after reset
    errs_at_start = err_cnt;
    @(negedge clk_i);
    check_bit("ready_start_o", 1'b1, ready_start_o);
    check_bit("busy_o", 1'b0, busy_o);
    check_bit("valid_o", 1'b0, valid_o);
    check_bit("done_o", 1'b0, done_o);
    for (int i = 0; i < stream_source_pkg::NB_PORTS; i++) begin
      check_bit($sformatf("mem_req_o[%0d]", i), 1'b0, mem_req_o[i]);
    end
    report_test("reset state", errs_at_start);

    run_job("linear 12 beats", 32'h0000_1000, 16'd12, 16'd12, 32'h0000_0060, 1'b0);
    run_job("2d 3x3 beats", 32'h2000_0040, 16'd9, 16'd3, 32'h0000_0100, 1'b0);
    run_job("random stalls 20 beats", 32'h0001_0000, 16'd20, 16'd5, 32'h0000_0040, 1'b1);
    run_job("random stalls 7 beats", 32'h0001_8008, 16'd7, 16'd7, 32'h0000_0000, 1'b1);
    run_job("random stalls 33 beats", 32'h0002_0010, 16'd33, 16'd4, 32'h0000_0030, 1'b1);
    clear_mid_job();
    run_job("job after clear", 32'h0004_0100, 16'd16, 16'd4, 32'h0000_0028, 1'b0);

    $display("tests %0d, checks %0d, errors %0d, beats %0d",
             test_cnt, check_cnt, err_cnt, beat_total);
    if (err_cnt == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule
